//--- filelist.f
verilog/memfy_pkg.sv
verilog/memfy_decode.sv
verilog/memfy_bus_fsm.sv
verilog/memfy_load_align.sv
verilog/memfy_top.sv
testbench/tb_clock.sv
testbench/memfy_props.sv
testbench/tb_memfy.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

SIM := obj_dir/Vtb_memfy
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): filelist.f verilog/*.sv testbench/*.sv
	verilator --binary --timing --assert --top-module tb_memfy -f filelist.f

run: $(SIM)
	-$(SIM) +verilator+error+limit+10 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_memfy.sv
/* Top of the load/store unit testbench: DUT, AXI4-lite memory with random
   back-pressure and random LOAD/STORE stimulus. Checking lives in memfy_props. */

module tb_memfy;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INST = 300;
    localparam int TIMEOUT  = 200;

    logic        aclk;
    logic        aresetn;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [1:0]  exceptions;
    logic        rd_wr;
    logic [4:0]  rd_addr;
    logic [31:0] rd_val;
    logic        awvalid;
    logic        awready = 1'b0;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready = 1'b0;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid = 1'b0;
    logic        bready;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [31:0] araddr;
    logic        rvalid = 1'b0;
    logic        rready;
    logic [31:0] rdata = 32'd0;

    // Memory slave state
    logic [31:0] mem [64];
    logic        aw_done;
    logic        w_done;
    logic        rd_pend;
    logic [5:0]  wr_idx;
    logic [5:0]  rd_idx;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic [31:0] lfsr_q = 32'd75005;

    tb_clock u_clock (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    memfy_top #(
        .ADDR_W (32)
    ) u_dut (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .exceptions (exceptions),
        .rd_wr      (rd_wr),
        .rd_addr    (rd_addr),
        .rd_val     (rd_val),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata)
    );

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    ////////////////////////////////////////
    // AXI4-lite memory
    ////////////////////////////////////////

    always @(posedge aclk or negedge aresetn) begin
        logic [31:0] r;
        if (!aresetn) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            rd_pend <= 1'b0;
            // Fill word mixes every address bit
            for (int i = 0; i < 64; i++) begin
                mem[i] <= (32'h9e3779b9 * (i + 1)) ^ (i << 20);
            end
        end else begin
            take_bits(5, r);
            awready <= r[0];
            wready  <= r[1];
            arready <= r[2];
            if (awvalid && awready) begin
                aw_done <= 1'b1;
                wr_idx  <= awaddr[7:2];
            end
            if (wvalid && wready) begin
                w_done  <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
            end
            // Write response at least one cycle after both channels
            if (aw_done && w_done && !bvalid && r[3]) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
                bvalid  <= 1'b1;
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rd_pend <= 1'b1;
                rd_idx  <= araddr[7:2];
            end
            if (rd_pend && !rvalid && r[4]) begin
                rvalid  <= 1'b1;
                rdata   <= mem[rd_idx];
                rd_pend <= 1'b0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic wait_reset_release();
        int cnt;
        cnt = 0;
        while (!aresetn) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("Reset was never released");
                $display("Testbench failed");
                $fatal(1);
            end
            @(negedge aclk);
        end
    endtask

    // inst_ready is read at the falling edge where it is settled
    task automatic wait_ready();
        int cnt;
        cnt = 0;
        @(negedge aclk);
        while (!inst_ready) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("Timeout waiting for inst_ready");
                $display("Testbench failed");
                $fatal(1);
            end
            @(negedge aclk);
        end
    endtask

    // Random load or store of any size, offsets come from rs1 and imm
    task automatic build_inst(output logic [31:0] ins, output logic [31:0] a,
                              output logic [31:0] b);
        logic [31:0] r;
        logic        st;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  rd;
        take_bits(1, r);
        st = r[0];
        take_bits(3, r);
        if (st) begin
            f3 = (r[1:0] == 2'd3) ? 3'b010 : {1'b0, r[1:0]};
        end else begin
            case (r[2:0])
                3'd3:    f3 = 3'b100;
                3'd4:    f3 = 3'b101;
                3'd5:    f3 = 3'b001;
                3'd6:    f3 = 3'b100;
                3'd7:    f3 = 3'b101;
                default: f3 = r[2:0];
            endcase
        end
        take_bits(12, r);
        imm = r[11:0];
        take_bits(5, r);
        rd = r[4:0];
        take_bits(32, a);
        take_bits(32, b);
        if (st) begin
            ins = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
        end else begin
            ins = {imm, 5'd1, f3, rd, 7'b0000011};
        end
    endtask

    // Any failed assertion ends the run at once
    always @(negedge aclk) begin
        if (u_dut.u_props.fail_seen) begin
            $display("Assertion failure reported by the checker");
            $display("Testbench failed");
            $fatal(1);
        end
    end

    initial begin
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        inst_valid = 1'b0;
        inst       = '0;
        rs1_val    = '0;
        rs2_val    = '0;
        @(negedge aclk);
        wait_reset_release();
        for (int n = 0; n < NUM_INST; n++) begin
            wait_ready();
            build_inst(ins, a, b);
            @(posedge aclk);
            inst_valid <= 1'b1;
            inst       <= ins;
            rs1_val    <= a;
            rs2_val    <= b;
            // inst_ready is high in IDLE, so this edge is the handshake
            @(posedge aclk);
            inst_valid <= 1'b0;
        end
        wait_ready();
        repeat (4) @(negedge aclk);
        if (u_dut.u_props.fail_seen) begin
            $display("Testbench failed");
            $fatal(1);
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- testbench/memfy_props.sv
/* Concurrent checks of the load/store unit, bound into memfy_top.
   Expected values are rebuilt from the RV32I encoding of the captured instruction. */

module memfy_props (
    input logic        aclk,
    input logic        aresetn,
    input logic        inst_valid,
    input logic        inst_ready,
    input logic [31:0] inst,
    input logic [31:0] rs1_val,
    input logic [31:0] rs2_val,
    input logic [1:0]  exceptions,
    input logic        rd_wr,
    input logic [4:0]  rd_addr,
    input logic [31:0] rd_val,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] awaddr,
    input logic        wvalid,
    input logic        wready,
    input logic [31:0] wdata,
    input logic [3:0]  wstrb,
    input logic        bvalid,
    input logic        bready,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    logic        fail_seen = 1'b0;
    logic [31:0] cap_inst;
    logic [31:0] cap_rs1;
    logic [31:0] cap_rs2;
    logic        inflight;
    logic        acc;
    logic        resp_hs;
    logic [31:0] cap_ea;
    logic [1:0]  cap_off;
    logic [3:0]  exp_strb;
    logic [31:0] exp_wdata;
    logic [31:0] exp_ld;
    logic [63:0] rot;

    ////////////////////////////////////////
    // Reference decode
    ////////////////////////////////////////

    function automatic logic is_st(input logic [31:0] i);
        return i[6:0] == 7'b0100011;
    endfunction

    // rs1 plus sign-extended I or S immediate
    function automatic logic [31:0] ea_of(input logic [31:0] i, input logic [31:0] r1);
        logic [11:0] imm;
        imm = is_st(i) ? {i[31:25], i[11:7]} : i[31:20];
        return r1 + {{20{imm[11]}}, imm};
    endfunction

    // Size from funct3[1:0]; halfword needs even, word needs zero offset
    function automatic logic mis_of(input logic [31:0] i, input logic [31:0] r1);
        logic [31:0] ea;
        ea = ea_of(i, r1);
        case (i[13:12])
            2'b01:   return ea[0];
            2'b10:   return ea[1:0] != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    assign acc     = inst_valid & inst_ready;
    assign resp_hs = (bvalid & bready) | (rvalid & rready);

    // Instruction and sources as seen at acceptance
    always_ff @(posedge aclk) begin
        if (acc) begin
            cap_inst <= inst;
            cap_rs1  <= rs1_val;
            cap_rs2  <= rs2_val;
        end
    end

    // One request between aligned acceptance and its response
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            inflight <= 1'b0;
        end else if (acc && !mis_of(inst, rs1_val)) begin
            inflight <= 1'b1;
        end else if (resp_hs) begin
            inflight <= 1'b0;
        end
    end

    assign cap_ea  = ea_of(cap_inst, cap_rs1);
    assign cap_off = cap_ea[1:0];

    // Store lanes: size pattern shifted up, data rotated left
    always_comb begin
        case (cap_inst[13:12])
            2'b00:   exp_strb = 4'b0001 << cap_off;
            2'b01:   exp_strb = 4'b0011 << cap_off;
            default: exp_strb = 4'b1111;
        endcase
        rot       = {cap_rs2, cap_rs2} << (8 * cap_off);
        exp_wdata = rot[63:32];
    end

    // Load field and extension from the raw read word
    always_comb begin
        logic [31:0] sh;
        sh = rdata >> (8 * cap_off);
        case (cap_inst[14:12])
            3'b000:  exp_ld = {{24{sh[7]}}, sh[7:0]};
            3'b001:  exp_ld = {{16{sh[15]}}, sh[15:0]};
            3'b100:  exp_ld = {24'd0, sh[7:0]};
            3'b101:  exp_ld = {16'd0, sh[15:0]};
            default: exp_ld = sh;
        endcase
    end

    ////////////////////////////////////////
    // Reset and handshake rules
    ////////////////////////////////////////

    // First cycle out of reset is IDLE with every channel quiet
    a_reset_idle: assert property (@(posedge aclk)
        $rose(aresetn) |-> !awvalid && !wvalid && !arvalid && !bready && !rready
                           && !rd_wr && inst_ready)
        else begin
            fail_seen = 1'b1;
            $error("Outputs not idle after reset");
        end

    a_aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            fail_seen = 1'b1;
            $error("awvalid or awaddr changed before awready");
        end

    a_w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else begin
            fail_seen = 1'b1;
            $error("wvalid or write data changed before wready");
        end

    a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            fail_seen = 1'b1;
            $error("arvalid or araddr changed before arready");
        end

    // Response ready only once every request channel of the kind in flight is done
    a_bready: assert property (@(posedge aclk) disable iff (!aresetn)
        bready == (inflight && is_st(cap_inst) && !awvalid && !wvalid))
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED bready expected %b actual %b",
                   inflight && is_st(cap_inst) && !awvalid && !wvalid, bready);
        end

    a_rready: assert property (@(posedge aclk) disable iff (!aresetn)
        rready == (inflight && !is_st(cap_inst) && !arvalid))
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED rready expected %b actual %b",
                   inflight && !is_st(cap_inst) && !arvalid, rready);
        end

    ////////////////////////////////////////
    // Payload rules
    ////////////////////////////////////////

    a_awaddr: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid |-> awaddr == cap_ea)
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED store_addr expected %h actual %h", cap_ea, awaddr);
        end

    a_wstrb: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid |-> wstrb == exp_strb)
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED store_strb expected %h actual %h", exp_strb, wstrb);
        end

    a_wdata: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid |-> wdata == exp_wdata)
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED store_data expected %h actual %h", exp_wdata, wdata);
        end

    a_araddr: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid |-> araddr == cap_ea)
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED load_addr expected %h actual %h", cap_ea, araddr);
        end

    // Register write exactly while read data is offered for a load in flight
    a_rd_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr == (rvalid && inflight && !is_st(cap_inst)))
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED rd_wr expected %b actual %b",
                   rvalid && inflight && !is_st(cap_inst), rd_wr);
        end

    a_rd_addr: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr |-> rd_addr == cap_inst[11:7])
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED load_rd expected %h actual %h", cap_inst[11:7], rd_addr);
        end

    a_rd_val: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_wr |-> rd_val == exp_ld)
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED load_value expected %h actual %h", exp_ld, rd_val);
        end

    ////////////////////////////////////////
    // Exceptions and sequencing
    ////////////////////////////////////////

    // Bit 0 load, bit 1 store, only in the acceptance cycle
    a_exc: assert property (@(posedge aclk) disable iff (!aresetn)
        exceptions == (acc && mis_of(inst, rs1_val) ? {is_st(inst), !is_st(inst)} : 2'b00))
        else begin
            fail_seen = 1'b1;
            $error("CHECK FAILED exceptions expected %b actual %b",
                   acc && mis_of(inst, rs1_val) ? {is_st(inst), !is_st(inst)} : 2'b00,
                   exceptions);
        end

    a_mis_no_issue: assert property (@(posedge aclk) disable iff (!aresetn)
        acc && mis_of(inst, rs1_val) |=> !awvalid && !wvalid && !arvalid && inst_ready)
        else begin
            fail_seen = 1'b1;
            $error("Misaligned access reached the bus");
        end

    a_st_issue: assert property (@(posedge aclk) disable iff (!aresetn)
        acc && !mis_of(inst, rs1_val) && is_st(inst) |=> awvalid && wvalid && !arvalid)
        else begin
            fail_seen = 1'b1;
            $error("Store not issued one cycle after acceptance");
        end

    a_ld_issue: assert property (@(posedge aclk) disable iff (!aresetn)
        acc && !mis_of(inst, rs1_val) && !is_st(inst) |=> arvalid && !awvalid && !wvalid)
        else begin
            fail_seen = 1'b1;
            $error("Load not issued one cycle after acceptance");
        end

    a_one_flight: assert property (@(posedge aclk) disable iff (!aresetn)
        inflight |-> !inst_ready)
        else begin
            fail_seen = 1'b1;
            $error("inst_ready high while a request is in flight");
        end

    a_ready_back: assert property (@(posedge aclk) disable iff (!aresetn)
        resp_hs |=> inst_ready)
        else begin
            fail_seen = 1'b1;
            $error("inst_ready did not return after the response");
        end

endmodule

bind memfy_top memfy_props u_props (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst       (inst),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .exceptions (exceptions),
    .rd_wr      (rd_wr),
    .rd_addr    (rd_addr),
    .rd_val     (rd_val),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata)
);

//--- testbench/tb_clock.sv
/* Testbench clock and reset source: 40 ns clock, reset low for 5 cycles */

module tb_clock (
    output logic aclk,
    output logic aresetn
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        aclk = 1'b0;
        forever begin
            #20 aclk = ~aclk;
        end
    end

    // Reset released on a rising edge
    initial begin
        aresetn = 1'b0;
        repeat (5) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

//--- verilog/memfy_top.sv
/* Load/store unit top level with an AXI4-lite master port.
   Ties decode, request sequencer and load alignment together. */

module memfy_top import memfy_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    // Instruction side
    input  logic              inst_valid,
    output logic              inst_ready,
    input  word_t             inst,
    input  word_t             rs1_val,
    input  word_t             rs2_val,
    output exc_t              exceptions,
    // Register write
    output logic              rd_wr,
    output reg_addr_t         rd_addr,
    output word_t             rd_val,
    // AXI4-lite master
    output logic              awvalid,
    input  logic              awready,
    output logic [ADDR_W-1:0] awaddr,
    output logic              wvalid,
    input  logic              wready,
    output word_t             wdata,
    output strb_t             wstrb,
    input  logic              bvalid,
    output logic              bready,
    output logic              arvalid,
    input  logic              arready,
    output logic [ADDR_W-1:0] araddr,
    input  logic              rvalid,
    output logic              rready,
    input  word_t             rdata
);

    logic       is_load;
    logic       is_store;
    logic       misaligned;
    logic       inst_hs;
    funct3_t    funct3;
    reg_addr_t  rd;
    word_t      addr;
    word_t      st_wdata;
    strb_t      st_wstrb;
    funct3_t    ld_funct3;
    logic [1:0] ld_offset;

    memfy_decode u_decode (
        .inst       (inst),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .is_load    (is_load),
        .is_store   (is_store),
        .funct3     (funct3),
        .rd         (rd),
        .addr       (addr),
        .misaligned (misaligned),
        .wdata      (st_wdata),
        .wstrb      (st_wstrb)
    );

    memfy_bus_fsm #(
        .ADDR_W (ADDR_W)
    ) u_bus_fsm (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .is_load    (is_load),
        .is_store   (is_store),
        .misaligned (misaligned),
        .funct3     (funct3),
        .rd         (rd),
        .addr       (addr),
        .wdata_in   (st_wdata),
        .wstrb_in   (st_wstrb),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .ld_funct3  (ld_funct3),
        .ld_offset  (ld_offset),
        .rd_wr      (rd_wr),
        .rd_addr    (rd_addr)
    );

    memfy_load_align u_load_align (
        .rdata     (rdata),
        .ld_funct3 (ld_funct3),
        .ld_offset (ld_offset),
        .rd_val    (rd_val)
    );

    ////////////////////////////////////////
    // Exceptions
    ////////////////////////////////////////

    // One-cycle pulse in the acceptance cycle, split by access kind
    assign inst_hs = inst_valid & inst_ready & misaligned;

    assign exceptions[EXC_LD_MA] = inst_hs & is_load;
    assign exceptions[EXC_ST_MA] = inst_hs & is_store;

endmodule

//--- verilog/memfy_load_align.sv
/* Combinational load alignment: shifts the read word down to the addressed
   byte and extends it to the register value. */

module memfy_load_align import memfy_pkg::*; (
    input  word_t      rdata,
    input  funct3_t    ld_funct3,
    input  logic [1:0] ld_offset,
    output word_t      rd_val
);

    word_t data_rot;

    // Addressed byte moved down to lane 0
    always_comb begin
        case (ld_offset)
            2'd1:    data_rot = {rdata[7:0],  rdata[31:8]};
            2'd2:    data_rot = {rdata[15:0], rdata[31:16]};
            2'd3:    data_rot = {rdata[23:0], rdata[31:24]};
            default: data_rot = rdata;
        endcase
    end

    // Field select and extension
    always_comb begin
        case (ld_funct3)
            F3_LB:   rd_val = {{24{data_rot[7]}}, data_rot[7:0]};
            F3_LBU:  rd_val = {24'd0, data_rot[7:0]};
            F3_LH:   rd_val = {{16{data_rot[15]}}, data_rot[15:0]};
            F3_LHU:  rd_val = {16'd0, data_rot[15:0]};
            F3_LW:   rd_val = data_rot;
            // Reserved sizes pass the word unchanged
            default: rd_val = data_rot;
        endcase
    end

endmodule

//--- verilog/memfy_bus_fsm.sv
/* Request sequencer: accepts one aligned LOAD or STORE, drives the AXI4-lite
   channels and holds the load context until the read response. */

module memfy_bus_fsm import memfy_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    // Instruction side
    input  logic              inst_valid,
    output logic              inst_ready,
    input  logic              is_load,
    input  logic              is_store,
    input  logic              misaligned,
    input  funct3_t           funct3,
    input  reg_addr_t         rd,
    input  word_t             addr,
    input  word_t             wdata_in,
    input  strb_t             wstrb_in,
    // Write address and data
    output logic              awvalid,
    input  logic              awready,
    output logic [ADDR_W-1:0] awaddr,
    output logic              wvalid,
    input  logic              wready,
    output word_t             wdata,
    output strb_t             wstrb,
    // Write response
    input  logic              bvalid,
    output logic              bready,
    // Read address and data
    output logic              arvalid,
    input  logic              arready,
    output logic [ADDR_W-1:0] araddr,
    input  logic              rvalid,
    output logic              rready,
    // Load context towards alignment and register write
    output funct3_t           ld_funct3,
    output logic [1:0]        ld_offset,
    output logic              rd_wr,
    output reg_addr_t         rd_addr
);

    lsu_state_e        state;
    logic              op_load;
    logic              accept;
    logic              aw_pend;
    logic              w_pend;
    logic              ar_pend;
    logic              resp_done;
    logic [ADDR_W-1:0] addr_q;

    // Only an aligned load or store starts a bus request
    assign inst_ready = (state == IDLE);
    assign accept     = inst_valid & inst_ready & (is_load | is_store) & ~misaligned;

    // Channels still waiting for their ready after this cycle
    assign aw_pend = awvalid & ~awready;
    assign w_pend  = wvalid & ~wready;
    assign ar_pend = arvalid & ~arready;

    // Response channel opened only for the kind in flight
    assign bready    = (state == RESP) & ~op_load;
    assign rready    = (state == RESP) & op_load;
    assign resp_done = (bvalid & bready) | (rvalid & rready);

    // Register write falls on the read handshake
    assign rd_wr = rvalid & rready;

    assign awaddr = addr_q;
    assign araddr = addr_q;

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= IDLE;
            op_load <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= ISSUE;
                        op_load <= is_load;
                        awvalid <= is_store;
                        wvalid  <= is_store;
                        arvalid <= is_load;
                    end
                end
                ISSUE: begin
                    // aw and w retire independently
                    awvalid <= aw_pend;
                    wvalid  <= w_pend;
                    arvalid <= ar_pend;
                    if (!aw_pend && !w_pend && !ar_pend) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (resp_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Request payload and load context
    ////////////////////////////////////////

    // Captured at acceptance, held stable through ISSUE and RESP
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q    <= addr[ADDR_W-1:0];
            wdata     <= wdata_in;
            wstrb     <= wstrb_in;
            ld_funct3 <= funct3;
            ld_offset <= addr[1:0];
            rd_addr   <= rd;
        end
    end

endmodule

//--- verilog/memfy_decode.sv
/* Combinational decode of a LOAD/STORE instruction: fields, effective address,
   alignment check and store byte lanes. */

module memfy_decode import memfy_pkg::*; (
    input  word_t     inst,
    input  word_t     rs1_val,
    input  word_t     rs2_val,
    output logic      is_load,
    output logic      is_store,
    output funct3_t   funct3,
    output reg_addr_t rd,
    output word_t     addr,
    output logic      misaligned,
    output word_t     wdata,
    output strb_t     wstrb
);

    opcode_t     opcode;
    logic [11:0] imm;
    logic [1:0]  offset;
    logic        ld_misaligned;
    logic        st_misaligned;
    strb_t       strb_base;

    ////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];

    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    // I-type immediate for loads, S-type split immediate for stores
    assign imm = is_store ? {inst[31:25], inst[11:7]} : inst[31:20];

    // Effective address, immediate sign-extended to a word
    assign addr   = rs1_val + {{20{imm[11]}}, imm};
    assign offset = addr[1:0];

    ////////////////////////////////////////
    // Alignment rules
    ////////////////////////////////////////

    // Halfword needs an even offset, word needs offset zero
    always_comb begin
        ld_misaligned = 1'b0;
        if ((funct3 == F3_LH) || (funct3 == F3_LHU)) begin
            ld_misaligned = offset[0];
        end else if (funct3 == F3_LW) begin
            ld_misaligned = |offset;
        end
    end

    always_comb begin
        st_misaligned = 1'b0;
        if (funct3 == F3_SH) begin
            st_misaligned = offset[0];
        end else if (funct3 == F3_SW) begin
            st_misaligned = |offset;
        end
    end

    assign misaligned = (is_load & ld_misaligned) | (is_store & st_misaligned);

    ////////////////////////////////////////
    // Store lanes
    ////////////////////////////////////////

    // Rotate the source value left so byte 0 lands on the addressed lane
    always_comb begin
        case (offset)
            2'd1:    wdata = {rs2_val[23:0], rs2_val[31:24]};
            2'd2:    wdata = {rs2_val[15:0], rs2_val[31:16]};
            2'd3:    wdata = {rs2_val[7:0],  rs2_val[31:8]};
            default: wdata = rs2_val;
        endcase
    end

    // Size pattern before the lane shift
    always_comb begin
        case (funct3)
            F3_SB:   strb_base = 4'b0001;
            F3_SH:   strb_base = 4'b0011;
            F3_SW:   strb_base = 4'b1111;
            default: strb_base = 4'b0000;
        endcase
    end

    assign wstrb = strb_base << offset;

endmodule

//--- verilog/memfy_pkg.sv
/* Shared types and constants of the load/store unit.
   Imported by every RTL module that needs them. */

package memfy_pkg;

    ////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////

    // Data and address word, XLEN fixed at 32
    typedef logic [31:0] word_t;
    // One strobe bit per byte lane
    typedef logic [3:0]  strb_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;

    // Bit 0 load misaligned, bit 1 store misaligned
    typedef logic [1:0]  exc_t;

    localparam int EXC_LD_MA = 0;
    localparam int EXC_ST_MA = 1;

    ////////////////////////////////////////
    // RV32I encodings
    ////////////////////////////////////////

    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // Load sizes and sign
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    // Store sizes
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    // Request sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        RESP  = 2'd2
    } lsu_state_e;

endpackage
